// File: rtl/board_pkg.sv
package board_pkg;

	// ************************************************************************
	// pin-side types
	// ************************************************************************

	localparam int unsigned GPIO_OUT_W = 4;	// gpio output pins

	// one 6-bit word, up in the msb
	typedef struct packed
	{
		logic up;
		logic down;
		logic left;
		logic right;
		logic a;
		logic b;
	} buttons_t;

	typedef struct packed
	{
		logic r;
		logic g;
		logic b;
	} rgb_t;

endpackage

// File: rtl/periph_pkg.sv
package periph_pkg;

	// ************************************************************************
	// apb3 request and response
	// ************************************************************************

	typedef struct packed
	{
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [15:0] pwdata;
	} apb_req_t;

	typedef struct packed
	{
		logic        pready;
		logic        pslverr;
		logic [15:0] prdata;
	} apb_rsp_t;

	// ************************************************************************
	// register map
	// ************************************************************************

	localparam logic [7:0] ADDR_GPIO_OUT  = 8'h00;
	localparam logic [7:0] ADDR_GPIO_IN   = 8'h04;	// read only
	localparam logic [7:0] ADDR_GPIO_EDGE = 8'h08;	// write 1 to clear
	localparam logic [7:0] ADDR_LED       = 8'h0C;
	localparam logic [7:0] ADDR_UART_DATA = 8'h10;	// write only, reads 0
	localparam logic [7:0] ADDR_UART_STAT = 8'h14;	// read only

	typedef enum logic [2:0]
	{
		GPIO_OUT,
		GPIO_IN,
		GPIO_EDGE,
		LED,
		UART_DATA,
		UART_STAT,
		NONE
	} reg_sel_t;

	// write strobe plus the decoded register, select is valid every cycle
	typedef struct packed
	{
		logic        we;
		reg_sel_t    sel;
		logic [15:0] data;
	} reg_wr_t;

	// led register fields
	localparam int unsigned LED_DUTY_W = 4;
	localparam int unsigned LED_R_LSB  = 0;
	localparam int unsigned LED_G_LSB  = 4;
	localparam int unsigned LED_B_LSB  = 8;

	localparam int unsigned UART_BUSY_BIT = 0;	// in UART_STAT

endpackage

// File: rtl/reset_hold.sv
module reset_hold #(
	parameter int unsigned RESET_HOLD = 16
)
(
	input  logic clk,
	input  logic arst_n,
	output logic sys_rst_n
);

	localparam int unsigned CNT_W = $clog2(RESET_HOLD + 1);

	logic [CNT_W-1:0] count;

	// internal reset asserts with arst_n, releases after the hold count
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			count     <= '0;
			sys_rst_n <= 1'b0;
		end
		else if (count == CNT_W'(RESET_HOLD))
		begin
			sys_rst_n <= 1'b1;	// saturated
		end
		else
		begin
			count <= count + 1'b1;
		end
	end

endmodule

// File: rtl/apb_ctrl.sv
module apb_ctrl
(
	input  logic                 clk,
	input  logic                 sys_rst_n,
	input  periph_pkg::apb_req_t apb_req,
	output periph_pkg::apb_rsp_t apb_rsp,
	output periph_pkg::reg_wr_t  reg_wr,
	input  logic [15:0]          gpio_rdata,
	input  logic [15:0]          led_rdata,
	input  logic [15:0]          uart_rdata,
	input  logic                 uart_busy
);

	import periph_pkg::*;

	// SETUP means psel was seen, so the bus is in its first access cycle
	typedef enum logic [1:0]
	{
		IDLE,
		SETUP,
		ACCESS,
		WAIT
	} state_t;

	state_t      state;
	state_t      state_nxt;
	reg_sel_t    sel;
	logic        err;
	logic        stall;
	logic        done;
	logic [15:0] rdata;

	// ************************************************************************
	// address decode
	// ************************************************************************

	always_comb
	begin
		case (apb_req.paddr)
			ADDR_GPIO_OUT:  sel = GPIO_OUT;
			ADDR_GPIO_IN:   sel = GPIO_IN;
			ADDR_GPIO_EDGE: sel = GPIO_EDGE;
			ADDR_LED:       sel = LED;
			ADDR_UART_DATA: sel = UART_DATA;
			ADDR_UART_STAT: sel = UART_STAT;
			default:        sel = NONE;
		endcase
	end

	assign err = (sel == NONE) ||
		(apb_req.pwrite && ((sel == GPIO_IN) || (sel == UART_STAT)));

	// uart data write has to wait for the frame in flight
	assign stall = apb_req.pwrite && (sel == UART_DATA) && uart_busy;

	// ************************************************************************
	// state machine
	// ************************************************************************

	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
				if (apb_req.psel)	// also a transfer held over reset
					state_nxt = SETUP;
			SETUP:
				state_nxt = stall ? WAIT : IDLE;
			WAIT:
				if (!uart_busy)
					state_nxt = ACCESS;	// complete next cycle
			default:
				state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge sys_rst_n)
	begin
		if (!sys_rst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	assign done = apb_req.psel && apb_req.penable &&
		(((state == SETUP) && !stall) || (state == ACCESS));

	always_comb
	begin
		case (sel)
			GPIO_OUT, GPIO_IN, GPIO_EDGE: rdata = gpio_rdata;
			LED:                          rdata = led_rdata;
			UART_DATA, UART_STAT:         rdata = uart_rdata;
			default:                      rdata = '0;
		endcase
	end

	assign apb_rsp.pready  = done;
	assign apb_rsp.pslverr = done && err;
	assign apb_rsp.prdata  = (done && !apb_req.pwrite) ? rdata : '0;

	assign reg_wr.we   = done && apb_req.pwrite && !err;	// one cycle strobe
	assign reg_wr.sel  = sel;
	assign reg_wr.data = apb_req.pwdata;

endmodule

// File: rtl/gpio_regs.sv
module gpio_regs
(
	input  logic                                 clk,
	input  logic                                 sys_rst_n,
	input  periph_pkg::reg_wr_t                  reg_wr,
	input  board_pkg::buttons_t                  buttons,
	output logic [board_pkg::GPIO_OUT_W-1:0]     gpio,
	output logic [15:0]                          rdata
);

	import periph_pkg::*;
	import board_pkg::*;

	buttons_t               sync1;
	buttons_t               sync2;
	buttons_t               sync_prev;
	logic [5:0]             rise;
	logic [5:0]             edge_q;
	logic [GPIO_OUT_W-1:0]  out_q;

	assign rise = sync2 & ~sync_prev;

	always_ff @(posedge clk or negedge sys_rst_n)
	begin
		if (!sys_rst_n)
		begin
			sync1     <= '0;
			sync2     <= '0;
			sync_prev <= '0;
			edge_q    <= '0;
			out_q     <= '0;
		end
		else
		begin
			sync1     <= buttons;	// pins are async
			sync2     <= sync1;
			sync_prev <= sync2;
			// new rising edge beats a clear in the same cycle
			if (reg_wr.we && (reg_wr.sel == GPIO_EDGE))
				edge_q <= (edge_q & ~reg_wr.data[5:0]) | rise;
			else
				edge_q <= edge_q | rise;
			if (reg_wr.we && (reg_wr.sel == GPIO_OUT))
				out_q <= reg_wr.data[GPIO_OUT_W-1:0];
		end
	end

	assign gpio = out_q;

	always_comb
	begin
		case (reg_wr.sel)
			GPIO_OUT:  rdata = {{(16 - GPIO_OUT_W){1'b0}}, out_q};
			GPIO_IN:   rdata = {10'b0, sync2};
			GPIO_EDGE: rdata = {10'b0, edge_q};
			default:   rdata = '0;
		endcase
	end

endmodule

// File: rtl/led_pwm.sv
module led_pwm
(
	input  logic                clk,
	input  logic                sys_rst_n,
	input  periph_pkg::reg_wr_t reg_wr,
	output board_pkg::rgb_t     led,
	output logic [15:0]         rdata
);

	import periph_pkg::*;

	logic [LED_DUTY_W-1:0] duty_r;
	logic [LED_DUTY_W-1:0] duty_g;
	logic [LED_DUTY_W-1:0] duty_b;
	logic [LED_DUTY_W-1:0] pwm_cnt;

	always_ff @(posedge clk or negedge sys_rst_n)
	begin
		if (!sys_rst_n)
		begin
			duty_r  <= '0;
			duty_g  <= '0;
			duty_b  <= '0;
			pwm_cnt <= '0;
			led     <= '0;
		end
		else
		begin
			pwm_cnt <= pwm_cnt + 1'b1;	// free running, wraps at 16
			if (reg_wr.we && (reg_wr.sel == LED))
			begin
				duty_r <= reg_wr.data[LED_R_LSB +: LED_DUTY_W];
				duty_g <= reg_wr.data[LED_G_LSB +: LED_DUTY_W];
				duty_b <= reg_wr.data[LED_B_LSB +: LED_DUTY_W];
			end
			led.r <= pwm_cnt < duty_r;	// d high cycles per period
			led.g <= pwm_cnt < duty_g;
			led.b <= pwm_cnt < duty_b;
		end
	end

	always_comb
	begin
		rdata = '0;
		if (reg_wr.sel == LED)
		begin
			rdata[LED_R_LSB +: LED_DUTY_W] = duty_r;
			rdata[LED_G_LSB +: LED_DUTY_W] = duty_g;
			rdata[LED_B_LSB +: LED_DUTY_W] = duty_b;
		end
	end

endmodule

// File: rtl/uart_tx.sv
module uart_tx #(
	parameter int unsigned BAUD_DIV = 217
)
(
	input  logic                clk,
	input  logic                sys_rst_n,
	input  periph_pkg::reg_wr_t reg_wr,
	output logic                txd,
	output logic                busy,
	output logic [15:0]         rdata
);

	import periph_pkg::*;

	localparam int unsigned CNT_W = $clog2(BAUD_DIV);

	logic [CNT_W-1:0] baud_cnt;
	logic [3:0]       bit_cnt;
	logic [9:0]       shreg;	// stop, data, start
	logic             load;

	assign load = reg_wr.we && (reg_wr.sel == UART_DATA);

	// ************************************************************************
	// 8N1 shifter
	// ************************************************************************

	always_ff @(posedge clk or negedge sys_rst_n)
	begin
		if (!sys_rst_n)
		begin
			shreg    <= '1;	// line idles high
			busy     <= 1'b0;
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end
		else if (load)
		begin
			shreg    <= {1'b1, reg_wr.data[7:0], 1'b0};
			busy     <= 1'b1;
			baud_cnt <= CNT_W'(BAUD_DIV - 1);
			bit_cnt  <= '0;
		end
		else if (busy)
		begin
			if (baud_cnt != '0)
			begin
				baud_cnt <= baud_cnt - 1'b1;
			end
			else
			begin
				baud_cnt <= CNT_W'(BAUD_DIV - 1);
				shreg    <= {1'b1, shreg[9:1]};	// lsb first
				if (bit_cnt == 4'd9)
					busy <= 1'b0;	// end of stop bit
				else
					bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	assign txd = shreg[0];

	always_comb
	begin
		rdata = '0;
		if (reg_wr.sel == UART_STAT)
			rdata[UART_BUSY_BIT] = busy;
	end

endmodule

// File: rtl/board_top.sv
module board_top #(
	parameter int unsigned RESET_HOLD = 16,
	parameter int unsigned BAUD_DIV   = 217
)
(
	input  logic                             clk,
	input  logic                             arst_n,
	input  periph_pkg::apb_req_t             apb_req,
	output periph_pkg::apb_rsp_t             apb_rsp,
	input  board_pkg::buttons_t              buttons,
	output logic [board_pkg::GPIO_OUT_W-1:0] gpio,
	output board_pkg::rgb_t                  led,
	output logic                             uart_txd
);

	import periph_pkg::*;

	logic        sys_rst_n;
	reg_wr_t     reg_wr;
	logic [15:0] gpio_rdata;
	logic [15:0] led_rdata;
	logic [15:0] uart_rdata;
	logic        uart_busy;

	reset_hold #(
		.RESET_HOLD(RESET_HOLD)
	) reset_hold0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.sys_rst_n (sys_rst_n)
	);

	apb_ctrl apb_ctrl0 (
		.clk        (clk),
		.sys_rst_n  (sys_rst_n),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.reg_wr     (reg_wr),
		.gpio_rdata (gpio_rdata),
		.led_rdata  (led_rdata),
		.uart_rdata (uart_rdata),
		.uart_busy  (uart_busy)
	);

	gpio_regs gpio_regs0 (
		.clk       (clk),
		.sys_rst_n (sys_rst_n),
		.reg_wr    (reg_wr),
		.buttons   (buttons),
		.gpio      (gpio),
		.rdata     (gpio_rdata)
	);

	led_pwm led_pwm0 (
		.clk       (clk),
		.sys_rst_n (sys_rst_n),
		.reg_wr    (reg_wr),
		.led       (led),
		.rdata     (led_rdata)
	);

	uart_tx #(
		.BAUD_DIV(BAUD_DIV)
	) uart_tx0 (
		.clk       (clk),
		.sys_rst_n (sys_rst_n),
		.reg_wr    (reg_wr),
		.txd       (uart_txd),
		.busy      (uart_busy),
		.rdata     (uart_rdata)
	);

endmodule

// File: verif/board_top_properties.sv
module board_top_properties
(
	input logic                 clk,
	input logic                 sys_rst_n,
	input periph_pkg::apb_rsp_t apb_rsp,
	input logic                 uart_txd,
	input logic                 uart_busy,
	input logic                 reg_we
);

	timeunit 1ns;
	timeprecision 100ps;

	// ************************************************************************
	// apb and uart rules
	// ************************************************************************

	assert property (@(posedge clk) apb_rsp.pslverr |-> apb_rsp.pready)
		else $error("pslverr raised without pready");

	assert property (@(posedge clk) disable iff (!sys_rst_n) !uart_busy |-> uart_txd)
		else $error("uart line low while transmitter idle");

	assert property (@(posedge clk) !sys_rst_n |-> !reg_we)
		else $error("register write strobe during internal reset");	// blocks still held

endmodule

bind board_top board_top_properties props0 (
	.clk       (clk),
	.sys_rst_n (sys_rst_n),
	.apb_rsp   (apb_rsp),
	.uart_txd  (uart_txd),
	.uart_busy (uart_busy),
	.reg_we    (reg_wr.we)
);

// File: verif/tb_board_top.sv
module tb_board_top;

	timeunit 1ns;
	timeprecision 100ps;

	import periph_pkg::*;

	localparam int unsigned RESET_HOLD = 8;
	localparam int unsigned BAUD_DIV   = 8;

	typedef enum {K_WR, K_RD, K_ERR_RD, K_ERR_WR, K_LED, K_UART} kind_t;

	typedef struct
	{
		string       name;
		kind_t       kind;
		logic [7:0]  addr;
		logic [15:0] data;
		logic [5:0]  btn;
		logic [15:0] exp;
	} entry_t;

	logic                clk;
	logic                arst_n;
	apb_req_t            apb_req;
	apb_rsp_t            apb_rsp;
	board_pkg::buttons_t buttons;
	logic [3:0]          gpio;
	board_pkg::rgb_t     led;
	logic                uart_txd;

	entry_t tbl[$];
	int     cyc = 0;
	int     done_cyc;
	int     last_load;
	bit     have_load = 0;
	int     n_ok = 0;
	int     n_bad = 0;

	board_top #(
		.RESET_HOLD(RESET_HOLD),
		.BAUD_DIV  (BAUD_DIV)
	) dut0 (
		.clk      (clk),
		.arst_n   (arst_n),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.buttons  (buttons),
		.gpio     (gpio),
		.led      (led),
		.uart_txd (uart_txd)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;	// read only at negedges

	// ************************************************************************
	// helpers
	// ************************************************************************

	task automatic add_entry(input string name, input kind_t kind, input logic [7:0] addr,
		input logic [15:0] data, input logic [5:0] btn, input logic [15:0] exp);
		entry_t e;
		e.name = name;
		e.kind = kind;
		e.addr = addr;
		e.data = data;
		e.btn  = btn;
		e.exp  = exp;
		tbl.push_back(e);
	endtask

	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [15:0] data,
		output logic [15:0] rdata, output logic err);
		@(posedge clk);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
		@(posedge clk);
		apb_req.penable <= 1'b1;
		@(negedge clk);
		while (!apb_rsp.pready)
			@(negedge clk);
		rdata    = apb_rsp.prdata;
		err      = apb_rsp.pslverr;
		done_cyc = cyc;	// completes on the next edge
		@(posedge clk);
		apb_req <= '0;
	endtask

	task automatic report(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (exp !== act)
		begin
			$display("ERROR %s: expected %h actual %h", name, exp, act);
			n_bad++;
		end
		else
		begin
			$display("%-14s ok", name);
			n_ok++;
		end
	endtask

	// ************************************************************************
	// stimulus
	// ************************************************************************

	initial
	begin
		logic [15:0] rd;
		logic        err;
		logic [15:0] act;
		logic [5:0]  b1;
		logic [5:0]  msk;
		logic [3:0]  g;
		logic [11:0] duty;
		logic [7:0]  u1;
		logic [7:0]  u2;
		logic [7:0]  u3;
		int          rel_cyc;
		int          cnt_r;
		int          cnt_g;
		int          cnt_b;
		clk     = 1'b0;
		arst_n  = 1'b0;
		apb_req = '0;
		buttons = '0;
		void'($urandom(91051));
		b1   = 6'($urandom_range(1, 63));
		msk  = 6'($urandom);
		g    = 4'($urandom_range(1, 15));
		duty = 12'($urandom);
		u1   = 8'($urandom);
		u2   = 8'($urandom);
		u3   = 8'($urandom);
		add_entry("rst_led", K_RD, ADDR_LED, 16'h0, 6'h0, 16'h0);
		add_entry("rst_edge", K_RD, ADDR_GPIO_EDGE, 16'h0, 6'h0, 16'h0);
		add_entry("rst_stat", K_RD, ADDR_UART_STAT, 16'h0, 6'h0, 16'h0);
		add_entry("gpio_out_wr", K_WR, ADDR_GPIO_OUT, 16'(g), 6'h0, 16'(g));
		add_entry("gpio_out_rd", K_RD, ADDR_GPIO_OUT, 16'h0, 6'h0, 16'(g));
		add_entry("gpio_in_rd", K_RD, ADDR_GPIO_IN, 16'h0, b1, 16'(b1));
		add_entry("edge_rd", K_RD, ADDR_GPIO_EDGE, 16'h0, b1, 16'(b1));
		add_entry("edge_clr", K_WR, ADDR_GPIO_EDGE, 16'(msk), b1, 16'h0);
		add_entry("edge_rd2", K_RD, ADDR_GPIO_EDGE, 16'h0, b1, 16'(b1 & ~msk));
		add_entry("led_wr", K_WR, ADDR_LED, 16'(duty), b1, 16'h0);
		add_entry("led_rd", K_RD, ADDR_LED, 16'h0, b1, 16'(duty));
		add_entry("led_count", K_LED, 8'h0, 16'h0, b1, 16'(duty));
		add_entry("uart_wr", K_WR, ADDR_UART_DATA, 16'(u1), b1, 16'h0);
		add_entry("uart_frame", K_UART, 8'h0, 16'h0, b1, {6'h0, 1'b1, u1, 1'b0});
		add_entry("bp_wr1", K_WR, ADDR_UART_DATA, 16'(u2), b1, 16'h0);
		add_entry("uart_stat", K_RD, ADDR_UART_STAT, 16'h0, b1, 16'h1);
		add_entry("bp_wr2", K_WR, ADDR_UART_DATA, 16'(u3), b1, 16'h0);
		add_entry("bp_frame", K_UART, 8'h0, 16'h0, b1, {6'h0, 1'b1, u3, 1'b0});
		add_entry("err_unmapped", K_ERR_RD, 8'h1C, 16'h0, b1, 16'h0);
		add_entry("err_gpio_in", K_ERR_WR, ADDR_GPIO_IN, 16'hFFFF, b1, 16'h0);
		add_entry("err_stat", K_ERR_WR, ADDR_UART_STAT, 16'hFFFF, b1, 16'h0);
		add_entry("edge_keep", K_RD, ADDR_GPIO_EDGE, 16'h0, b1, 16'(b1 & ~msk));
		add_entry("gpio_out_keep", K_RD, ADDR_GPIO_OUT, 16'h0, b1, 16'(g));

		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		rel_cyc = cyc;
		apb_xfer(1'b0, ADDR_GPIO_OUT, 16'h0, rd, err);
		if (done_cyc - rel_cyc < int'(RESET_HOLD))
			report("reset_hold", 16'(RESET_HOLD), 16'(done_cyc - rel_cyc));
		else if (uart_txd !== 1'b1)
			report("reset_txd", 16'h1, 16'(uart_txd));
		else
			report("reset_hold", 16'h0, rd);

		foreach (tbl[i])
		begin
			if (tbl[i].kind != K_LED && tbl[i].kind != K_UART)
			begin
				@(posedge clk);
				buttons <= tbl[i].btn;
				repeat (4) @(posedge clk);	// sync plus edge capture
			end
			case (tbl[i].kind)
				K_WR:
				begin
					apb_xfer(1'b1, tbl[i].addr, tbl[i].data, rd, err);
					act = {15'h0, err};
					if (!err && tbl[i].addr == ADDR_GPIO_OUT)
					begin
						@(negedge clk);
						act = 16'(gpio);
					end
					if (!err && tbl[i].addr == ADDR_UART_DATA)
					begin
						if (have_load && done_cyc < last_load + 10 * BAUD_DIV)
							report(tbl[i].name, 16'(last_load + 10 * BAUD_DIV),
								16'(done_cyc));
						else
							report(tbl[i].name, tbl[i].exp, act);
						last_load = done_cyc;
						have_load = 1'b1;
					end
					else
						report(tbl[i].name, tbl[i].exp, act);
				end
				K_RD:
				begin
					apb_xfer(1'b0, tbl[i].addr, 16'h0, rd, err);
					if (err)
						report(tbl[i].name, 16'h0, 16'h1);	// pslverr flag
					else
						report(tbl[i].name, tbl[i].exp, rd);
				end
				K_ERR_RD, K_ERR_WR:
				begin
					apb_xfer(tbl[i].kind == K_ERR_WR, tbl[i].addr, tbl[i].data, rd, err);
					report(tbl[i].name, 16'h1, {15'h0, err});
				end
				K_LED:
				begin
					cnt_r = 0;
					cnt_g = 0;
					cnt_b = 0;
					repeat (16)
					begin
						@(negedge clk);
						cnt_r += int'(led.r);
						cnt_g += int'(led.g);
						cnt_b += int'(led.b);
					end
					report(tbl[i].name, tbl[i].exp, 16'(cnt_r + cnt_g * 16 + cnt_b * 256));
				end
				default:
				begin
					act = '0;
					for (int k = 0; k < 10; k++)
					begin
						while (cyc < last_load + 1 + k * BAUD_DIV + BAUD_DIV / 2)
							@(negedge clk);
						act[k] = uart_txd;	// bit centre
					end
					report(tbl[i].name, tbl[i].exp, act);
				end
			endcase
		end

		$display("tests %0d  ok %0d  failed %0d", n_ok + n_bad, n_ok, n_bad);
		if (n_bad == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// run limit scales with the table length
	initial
	begin
		@(posedge clk);	// table is built at time zero
		repeat ((tbl.size() + 1) * 20 * BAUD_DIV) @(posedge clk);
		$display("watchdog: tests did not finish in time");
		$display("** FAIL **");
		$finish;
	end

endmodule

// File: flist.f
rtl/board_pkg.sv
rtl/periph_pkg.sv
rtl/reset_hold.sv
rtl/apb_ctrl.sv
rtl/gpio_regs.sv
rtl/led_pwm.sv
rtl/uart_tx.sv
rtl/board_top.sv
verif/board_top_properties.sv
verif/tb_board_top.sv

// File: run.sh
#!/bin/sh
# Build and run the board_top testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_board_top -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
	exit 1
fi
exit 0
